// ==== design/stream_fifo.sv ====
/* Synchronous show-ahead FIFO with valid/ready on both sides
   Payload type is a parameter so one block serves beats and headers */

`timescale 1ns/10ps
`default_nettype none

module stream_fifo #(
    parameter int  DEPTH  = 16,            // Power of two
    parameter type item_t = logic [7:0]
) (
    input  wire   clk,
    input  wire   rst,

    input  wire   push_valid,
    input  item_t push_data,
    output logic  push_ready,

    output logic  pop_valid,
    output item_t pop_data,
    input  wire   pop_ready
);

    localparam int AW = $clog2(DEPTH);

    item_t        mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          push;
    logic          pop;

    assign push_ready = (count != DEPTH[AW:0]);
    assign pop_valid  = (count != '0);
    assign pop_data   = mem[rd_ptr];   // Head is always on the output

    assign push = push_valid && push_ready;
    assign pop  = pop_valid && pop_ready;

    // Storage
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // Pointers wrap on their own since DEPTH is a power of two
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // Idle or push and pop together
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== design/udp_echo_pkg.sv ====
/* UDP echo engine shared types
   Address, port, payload beat and reply header definitions */

`default_nettype none

package udp_echo_pkg;

    // Basic field types
    typedef logic [7:0]  byte_t;
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] udp_port_t;
    typedef logic [15:0] udp_len_t;

    // One payload stream beat, 10 bits
    typedef struct packed {
        byte_t data;
        logic  last;   // Final byte of the frame
        logic  user;   // Error flag from the stack
    } payload_beat_t;

    // Reply header handed to the downstream stack, 112 bits
    typedef struct packed {
        ip_addr_t  source_ip;
        ip_addr_t  dest_ip;
        udp_port_t source_port;
        udp_port_t dest_port;
        udp_len_t  length;     // Copied from the received frame
    } reply_hdr_t;

    // Default echo service port
    localparam udp_port_t DEFAULT_ECHO_PORT = 16'd1234;

    // Default local address 192.168.1.128
    localparam ip_addr_t DEFAULT_LOCAL_IP = {8'd192, 8'd168, 8'd1, 8'd128};

endpackage

`default_nettype wire

// ==== design/udp_echo_top.sv ====
/* UDP echo engine top level
   Steer, header and payload queues, and the reply sequencer */

`timescale 1ns/10ps
`default_nettype none

module udp_echo_top
    import udp_echo_pkg::*;
#(
    parameter udp_port_t ECHO_PORT          = DEFAULT_ECHO_PORT,
    parameter ip_addr_t  LOCAL_IP           = DEFAULT_LOCAL_IP,
    parameter int        PAYLOAD_FIFO_DEPTH = 8192,
    parameter int        HDR_FIFO_DEPTH     = 4
) (
    input  wire       clk,
    input  wire       rst,

    // Received UDP frames
    input  wire       rx_hdr_valid,
    output logic      rx_hdr_ready,
    input  ip_addr_t  rx_ip_source_ip,
    input  udp_port_t rx_source_port,
    input  udp_port_t rx_dest_port,
    input  udp_len_t  rx_length,
    input  byte_t     rx_payload_tdata,
    input  wire       rx_payload_tvalid,
    output logic      rx_payload_tready,
    input  wire       rx_payload_tlast,
    input  wire       rx_payload_tuser,

    // Reply UDP frames
    output logic      tx_hdr_valid,
    input  wire       tx_hdr_ready,
    output ip_addr_t  tx_ip_source_ip,
    output ip_addr_t  tx_ip_dest_ip,
    output udp_port_t tx_source_port,
    output udp_port_t tx_dest_port,
    output udp_len_t  tx_length,
    output byte_t     tx_payload_tdata,
    output logic      tx_payload_tvalid,
    input  wire       tx_payload_tready,
    output logic      tx_payload_tlast,
    output logic      tx_payload_tuser,

    output byte_t     led
);

    // Header queue
    logic          hdr_push_valid;
    reply_hdr_t    hdr_push_data;
    logic          hdr_push_ready;
    logic          hdr_pop_valid;
    reply_hdr_t    hdr_pop_data;
    logic          hdr_pop_ready;

    // Payload queue
    logic          beat_push_valid;
    payload_beat_t beat_push_data;
    logic          beat_push_ready;
    logic          beat_pop_valid;
    payload_beat_t beat_pop_data;
    logic          beat_pop_ready;

    udp_rx_steer #(
        .ECHO_PORT (ECHO_PORT),
        .LOCAL_IP  (LOCAL_IP)
    ) steer_inst (
        .clk               (clk),
        .rst               (rst),
        .rx_hdr_valid      (rx_hdr_valid),
        .rx_hdr_ready      (rx_hdr_ready),
        .rx_ip_source_ip   (rx_ip_source_ip),
        .rx_source_port    (rx_source_port),
        .rx_dest_port      (rx_dest_port),
        .rx_length         (rx_length),
        .rx_payload_tdata  (rx_payload_tdata),
        .rx_payload_tvalid (rx_payload_tvalid),
        .rx_payload_tready (rx_payload_tready),
        .rx_payload_tlast  (rx_payload_tlast),
        .rx_payload_tuser  (rx_payload_tuser),
        .hdr_push_valid    (hdr_push_valid),
        .hdr_push_data     (hdr_push_data),
        .hdr_push_ready    (hdr_push_ready),
        .beat_push_valid   (beat_push_valid),
        .beat_push_data    (beat_push_data),
        .beat_push_ready   (beat_push_ready)
    );

    // A few headers let several replies wait in line
    stream_fifo #(
        .DEPTH  (HDR_FIFO_DEPTH),
        .item_t (reply_hdr_t)
    ) hdr_fifo (
        .clk        (clk),
        .rst        (rst),
        .push_valid (hdr_push_valid),
        .push_data  (hdr_push_data),
        .push_ready (hdr_push_ready),
        .pop_valid  (hdr_pop_valid),
        .pop_data   (hdr_pop_data),
        .pop_ready  (hdr_pop_ready)
    );

    stream_fifo #(
        .DEPTH  (PAYLOAD_FIFO_DEPTH),
        .item_t (payload_beat_t)
    ) payload_fifo (
        .clk        (clk),
        .rst        (rst),
        .push_valid (beat_push_valid),
        .push_data  (beat_push_data),
        .push_ready (beat_push_ready),
        .pop_valid  (beat_pop_valid),
        .pop_data   (beat_pop_data),
        .pop_ready  (beat_pop_ready)
    );

    udp_tx_sequencer seq_inst (
        .clk               (clk),
        .rst               (rst),
        .hdr_pop_valid     (hdr_pop_valid),
        .hdr_pop_data      (hdr_pop_data),
        .hdr_pop_ready     (hdr_pop_ready),
        .beat_pop_valid    (beat_pop_valid),
        .beat_pop_data     (beat_pop_data),
        .beat_pop_ready    (beat_pop_ready),
        .tx_hdr_valid      (tx_hdr_valid),
        .tx_hdr_ready      (tx_hdr_ready),
        .tx_ip_source_ip   (tx_ip_source_ip),
        .tx_ip_dest_ip     (tx_ip_dest_ip),
        .tx_source_port    (tx_source_port),
        .tx_dest_port      (tx_dest_port),
        .tx_length         (tx_length),
        .tx_payload_tdata  (tx_payload_tdata),
        .tx_payload_tvalid (tx_payload_tvalid),
        .tx_payload_tready (tx_payload_tready),
        .tx_payload_tlast  (tx_payload_tlast),
        .tx_payload_tuser  (tx_payload_tuser),
        .led               (led)
    );

endmodule

`default_nettype wire

// ==== design/udp_rx_steer.sv ====
/* Receive-side steering for the UDP echo engine
   Matches the destination port, builds the reply header and routes payload */

`timescale 1ns/10ps
`default_nettype none

module udp_rx_steer
    import udp_echo_pkg::*;
#(
    parameter udp_port_t ECHO_PORT = DEFAULT_ECHO_PORT,
    parameter ip_addr_t  LOCAL_IP  = DEFAULT_LOCAL_IP
) (
    input  wire           clk,
    input  wire           rst,

    // Received UDP header
    input  wire           rx_hdr_valid,
    output logic          rx_hdr_ready,
    input  ip_addr_t      rx_ip_source_ip,
    input  udp_port_t     rx_source_port,
    input  udp_port_t     rx_dest_port,
    input  udp_len_t      rx_length,

    // Received UDP payload
    input  byte_t         rx_payload_tdata,
    input  wire           rx_payload_tvalid,
    output logic          rx_payload_tready,
    input  wire           rx_payload_tlast,
    input  wire           rx_payload_tuser,

    // Into the header FIFO
    output logic          hdr_push_valid,
    output reply_hdr_t    hdr_push_data,
    input  wire           hdr_push_ready,

    // Into the payload FIFO
    output logic          beat_push_valid,
    output payload_beat_t beat_push_data,
    input  wire           beat_push_ready
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_FORWARD,
        ST_DROP
    } steer_state_t;

    steer_state_t state;
    logic         port_match;
    logic         hdr_xfer;
    logic         last_xfer;

    assign port_match = (rx_dest_port == ECHO_PORT);

    // A matching header needs room in the header queue, others go straight through
    assign rx_hdr_ready   = (state == ST_IDLE) && (!port_match || hdr_push_ready);
    assign hdr_push_valid = (state == ST_IDLE) && rx_hdr_valid && port_match;

    // Reply header, ports swapped and sender becomes the destination
    always_comb begin
        hdr_push_data.source_ip   = LOCAL_IP;
        hdr_push_data.dest_ip     = rx_ip_source_ip;
        hdr_push_data.source_port = rx_dest_port;
        hdr_push_data.dest_port   = rx_source_port;
        hdr_push_data.length      = rx_length;
    end

    assign beat_push_valid     = (state == ST_FORWARD) && rx_payload_tvalid;
    assign beat_push_data.data = rx_payload_tdata;
    assign beat_push_data.last = rx_payload_tlast;
    assign beat_push_data.user = rx_payload_tuser;

    // Drop state drains the stream unconditionally
    always_comb begin
        case (state)
            ST_FORWARD: rx_payload_tready = beat_push_ready;
            ST_DROP:    rx_payload_tready = 1'b1;
            default:    rx_payload_tready = 1'b0;
        endcase
    end

    assign hdr_xfer  = rx_hdr_valid && rx_hdr_ready;
    assign last_xfer = rx_payload_tvalid && rx_payload_tready && rx_payload_tlast;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (hdr_xfer) begin
                        state <= port_match ? ST_FORWARD : ST_DROP;
                    end
                end
                ST_FORWARD, ST_DROP: begin
                    if (last_xfer) begin
                        state <= ST_IDLE;   // Frame done
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== design/udp_tx_sequencer.sv ====
/* Transmit-side sequencer for the UDP echo engine
   Sends each queued reply header, then its payload, and shows the first byte */

`timescale 1ns/10ps
`default_nettype none

module udp_tx_sequencer
    import udp_echo_pkg::*;
(
    input  wire           clk,
    input  wire           rst,

    // From the header FIFO
    input  wire           hdr_pop_valid,
    input  reply_hdr_t    hdr_pop_data,
    output logic          hdr_pop_ready,

    // From the payload FIFO
    input  wire           beat_pop_valid,
    input  payload_beat_t beat_pop_data,
    output logic          beat_pop_ready,

    // Reply header to the stack
    output logic          tx_hdr_valid,
    input  wire           tx_hdr_ready,
    output ip_addr_t      tx_ip_source_ip,
    output ip_addr_t      tx_ip_dest_ip,
    output udp_port_t     tx_source_port,
    output udp_port_t     tx_dest_port,
    output udp_len_t      tx_length,

    // Reply payload to the stack
    output byte_t         tx_payload_tdata,
    output logic          tx_payload_tvalid,
    input  wire           tx_payload_tready,
    output logic          tx_payload_tlast,
    output logic          tx_payload_tuser,

    output byte_t         led
);

    typedef enum logic {
        ST_HDR,
        ST_PAYLOAD
    } seq_state_t;

    seq_state_t state;
    logic       first_beat;    // Next beat opens a frame
    logic       hdr_xfer;
    logic       beat_xfer;

    // Header path, head of the queue shown directly
    assign tx_hdr_valid    = (state == ST_HDR) && hdr_pop_valid;
    assign hdr_pop_ready   = (state == ST_HDR) && tx_hdr_ready;
    assign tx_ip_source_ip = hdr_pop_data.source_ip;
    assign tx_ip_dest_ip   = hdr_pop_data.dest_ip;
    assign tx_source_port  = hdr_pop_data.source_port;
    assign tx_dest_port    = hdr_pop_data.dest_port;
    assign tx_length       = hdr_pop_data.length;

    // Payload path
    assign tx_payload_tvalid = (state == ST_PAYLOAD) && beat_pop_valid;
    assign beat_pop_ready    = (state == ST_PAYLOAD) && tx_payload_tready;
    assign tx_payload_tdata  = beat_pop_data.data;
    assign tx_payload_tlast  = beat_pop_data.last;
    assign tx_payload_tuser  = beat_pop_data.user;

    assign hdr_xfer  = tx_hdr_valid && tx_hdr_ready;
    assign beat_xfer = tx_payload_tvalid && tx_payload_tready;

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= ST_HDR;
            first_beat <= 1'b0;
            led        <= '0;
        end else begin
            case (state)
                ST_HDR: begin
                    if (hdr_xfer) begin
                        state      <= ST_PAYLOAD;
                        first_beat <= 1'b1;
                    end
                end
                ST_PAYLOAD: begin
                    if (beat_xfer) begin
                        first_beat <= 1'b0;
                        if (first_beat) begin
                            led <= beat_pop_data.data;   // Opening byte of the frame
                        end
                        if (beat_pop_data.last) begin
                            state <= ST_HDR;
                        end
                    end
                end
                default: state <= ST_HDR;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== dv/udp_echo_tests.svh ====
/* Directed tests for the UDP echo engine
   Frame sender with reply expectations, reply wait and the test tasks */

`ifndef UDP_ECHO_TESTS_SVH
`define UDP_ECHO_TESTS_SVH

// Sends one frame and queues the reply it should produce
task automatic send_frame(input ip_addr_t src_ip, input udp_port_t src_port,
                          input udp_port_t dst_port, input int n, input logic user_flag);
    byte_t         data [$];
    payload_beat_t beat;
    reply_hdr_t    hdr;
    int            stalls;
    int            i;
    stalls = 0;
    for (i = 0; i < n; i++) begin
        data_state = lcg_step(data_state);
        data.push_back(data_state[23:16]);
    end
    if (dst_port == ECHO_PORT) begin
        hdr.source_ip   = LOCAL_IP;
        hdr.dest_ip     = src_ip;      // Reply goes back to the sender
        hdr.source_port = dst_port;
        hdr.dest_port   = src_port;
        hdr.length      = udp_len_t'(n + 8);
        exp_hdrs.push_back(hdr);
        for (i = 0; i < n; i++) begin
            beat.data = data[i];
            beat.last = (i == n - 1);
            beat.user = user_flag && (i == n - 1);
            exp_beats.push_back(beat);
        end
        exp_leds.push_back(data[0]);
        last_led = data[0];
    end
    rx_ip_source_ip = src_ip;
    rx_source_port  = src_port;
    rx_dest_port    = dst_port;
    rx_length       = udp_len_t'(n + 8);   // UDP length counts its 8-byte header
    rx_hdr_valid    = 1'b1;
    @(posedge clk);
    while (!rx_hdr_ready) begin
        stalls++;
        @(posedge clk);
    end
    #1 rx_hdr_valid = 1'b0;
    for (i = 0; i < n; i++) begin
        rx_payload_tdata  = data[i];
        rx_payload_tvalid = 1'b1;
        rx_payload_tlast  = (i == n - 1);
        rx_payload_tuser  = user_flag && (i == n - 1);
        @(posedge clk);
        while (!rx_payload_tready) begin
            stalls++;
            @(posedge clk);
        end
        bytes_sent++;
        #1;
    end
    rx_payload_tvalid = 1'b0;
    rx_payload_tlast  = 1'b0;
    rx_payload_tuser  = 1'b0;
    if (dst_port != ECHO_PORT && stalls != 0) begin
        $display("Dropped frame to port %0d stalled the input for %0d cycles", dst_port, stalls);
        failures++;
    end
endtask

// Waits for every queued reply, with a limit based on what is outstanding
task automatic wait_replies();
    int limit;
    int waited;
    limit  = 200 * (exp_beats.size() + 1) + 100;
    waited = 0;
    while ((exp_hdrs.size() != 0 || exp_beats.size() != 0 || exp_leds.size() != 0)
           && waited < limit) begin
        @(posedge clk);
        #2 waited++;
    end
    if (exp_hdrs.size() != 0 || exp_beats.size() != 0) begin
        $display("Missing reply: %0d headers and %0d payload bytes never arrived",
                 exp_hdrs.size(), exp_beats.size());
        failures++;
        exp_hdrs.delete();
        exp_beats.delete();
        exp_leds.delete();
    end
    @(posedge clk);
    #1;
endtask

task automatic test_reset_state();
    check_flag(tx_hdr_valid, 1'b0, "tx_hdr_valid after reset");
    check_flag(tx_payload_tvalid, 1'b0, "tx_payload_tvalid after reset");
    check_led(led, 8'h00, "led after reset");
endtask

task automatic test_echo();
    send_frame({8'd10, 8'd0, 8'd0, 8'd7}, 16'd5000, ECHO_PORT, 5, 1'b0);
    wait_replies();
    send_frame({8'd10, 8'd0, 8'd0, 8'd9}, 16'd40000, ECHO_PORT, 1, 1'b1);   // Single byte
    wait_replies();
endtask

task automatic test_drop();
    byte_t led_before;
    led_before = last_led;
    send_frame({8'd10, 8'd1, 8'd2, 8'd3}, 16'd5001, 16'd80, 6, 1'b0);
    send_frame({8'd10, 8'd1, 8'd2, 8'd4}, 16'd5002, udp_port_t'(ECHO_PORT + 1), 3, 1'b1);
    repeat (30) @(posedge clk);   // Any stray reply shows up in the monitor
    #1 check_led(led, led_before, "led after dropped frames");
endtask

task automatic test_mixed();
    int k;
    for (k = 0; k < 8; k++) begin
        send_frame({8'd172, 8'd16, 8'd0, 8'(k)}, udp_port_t'(6000 + k),
                   (k % 3 == 1) ? 16'd53 : ECHO_PORT, 2 + k, k[0]);
    end
    wait_replies();
endtask

// Slow tx side lets headers and payload pile up in the queues
task automatic test_back_pressure();
    int k;
    bp_enable = 1'b1;
    for (k = 0; k < 6; k++) begin
        send_frame({8'd192, 8'd168, 8'd1, 8'(20 + k)}, udp_port_t'(7000 + k),
                   (k == 3) ? 16'd9999 : ECHO_PORT, 3 + 2 * k, k[0]);
    end
    wait_replies();
    bp_enable = 1'b0;
endtask

`endif

// ==== dv/udp_echo_tb.sv ====
/* Testbench for the UDP echo engine
   Reply monitor, checks, watchdog and the directed test run */

`timescale 1ns/10ps
`default_nettype none

module udp_echo_tb
    import udp_echo_pkg::*;
();

    localparam ip_addr_t  LOCAL_IP        = DEFAULT_LOCAL_IP;
    localparam udp_port_t ECHO_PORT       = DEFAULT_ECHO_PORT;
    localparam int        WATCHDOG_MARGIN = 2000;   // Cycles on top of the per-byte budget

    logic          clk;
    logic          rst;
    logic          rx_hdr_valid;
    logic          rx_hdr_ready;
    ip_addr_t      rx_ip_source_ip;
    udp_port_t     rx_source_port;
    udp_port_t     rx_dest_port;
    udp_len_t      rx_length;
    byte_t         rx_payload_tdata;
    logic          rx_payload_tvalid;
    logic          rx_payload_tready;
    logic          rx_payload_tlast;
    logic          rx_payload_tuser;
    logic          tx_hdr_valid;
    logic          tx_hdr_ready;
    ip_addr_t      tx_ip_source_ip;
    ip_addr_t      tx_ip_dest_ip;
    udp_port_t     tx_source_port;
    udp_port_t     tx_dest_port;
    udp_len_t      tx_length;
    byte_t         tx_payload_tdata;
    logic          tx_payload_tvalid;
    logic          tx_payload_tready;
    logic          tx_payload_tlast;
    logic          tx_payload_tuser;
    byte_t         led;

    int            mismatches;
    int            failures;
    int            bytes_sent;
    int            cycles;
    logic          bp_enable;      // Random tx readies when set
    logic [31:0]   bp_state;
    logic [31:0]   data_state;
    byte_t         last_led;       // LED value the echoed frames should leave
    reply_hdr_t    exp_hdrs [$];
    payload_beat_t exp_beats [$];
    byte_t         exp_leds [$];
    reply_hdr_t    got_hdr;
    payload_beat_t got_beat;

    udp_echo_top #(.PAYLOAD_FIFO_DEPTH(64)) UUT (.*);

    always #5 clk = ~clk;

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic check_hdr(input reply_hdr_t got, input reply_hdr_t exp, input string msg);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, msg, got, exp);
            mismatches++;
        end
    endtask

    task automatic check_beat(input payload_beat_t got, input payload_beat_t exp,
                              input string msg);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, msg, got, exp);
            mismatches++;
        end
    endtask

    task automatic check_led(input byte_t got, input byte_t exp, input string msg);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, msg, got, exp);
            mismatches++;
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string msg);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %b expected %b", $time, msg, got, exp);
            mismatches++;
        end
    endtask

    // Tx readies, held high unless back-pressure is on
    always @(posedge clk) begin
        #1;
        if (bp_enable) begin
            bp_state          = lcg_step(bp_state);
            tx_hdr_ready      = bp_state[28];
            tx_payload_tready = bp_state[24];
        end else begin
            tx_hdr_ready      = 1'b1;
            tx_payload_tready = 1'b1;
        end
    end

    // Reply monitor, compares every transfer against the expected queues
    always @(posedge clk) begin
        if (tx_hdr_valid && tx_hdr_ready) begin
            got_hdr.source_ip   = tx_ip_source_ip;
            got_hdr.dest_ip     = tx_ip_dest_ip;
            got_hdr.source_port = tx_source_port;
            got_hdr.dest_port   = tx_dest_port;
            got_hdr.length      = tx_length;
            if (exp_hdrs.size() == 0) begin
                $display("Unexpected reply header at %0t", $time);
                failures++;
            end else begin
                check_hdr(got_hdr, exp_hdrs.pop_front(), "reply header");
            end
        end
        if (tx_payload_tvalid && tx_payload_tready) begin
            got_beat.data = tx_payload_tdata;
            got_beat.last = tx_payload_tlast;
            got_beat.user = tx_payload_tuser;
            if (exp_beats.size() == 0) begin
                $display("Unexpected reply payload byte at %0t", $time);
                failures++;
            end else begin
                check_beat(got_beat, exp_beats.pop_front(), "reply beat");
            end
            if (got_beat.last && exp_leds.size() != 0) begin
                #1 check_led(led, exp_leds.pop_front(), "led after echoed frame");
            end
        end
    end

    // Budget grows with every byte the sender gets accepted
    initial begin
        cycles = 0;
        while (cycles <= 200 * bytes_sent + WATCHDOG_MARGIN) begin
            @(posedge clk);
            cycles++;
        end
        $display("Watchdog expired after %0d cycles with %0d bytes sent", cycles, bytes_sent);
        $display("Test failed");
        $finish;
    end

    initial begin
        clk               = 1'b0;
        rst               = 1'b1;
        rx_hdr_valid      = 1'b0;
        rx_ip_source_ip   = '0;
        rx_source_port    = '0;
        rx_dest_port      = '0;
        rx_length         = '0;
        rx_payload_tdata  = '0;
        rx_payload_tvalid = 1'b0;
        rx_payload_tlast  = 1'b0;
        rx_payload_tuser  = 1'b0;
        tx_hdr_ready      = 1'b1;
        tx_payload_tready = 1'b1;
        mismatches        = 0;
        failures          = 0;
        bytes_sent        = 0;
        bp_enable         = 1'b0;
        bp_state          = 32'd3;
        data_state        = 32'd3;
        last_led          = '0;
        repeat (5) @(posedge clk);
        #1 rst = 1'b0;
        test_reset_state();
        test_echo();
        test_drop();
        test_mixed();
        test_back_pressure();
        $display("Mismatches: %0d, other failures: %0d", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    `include "udp_echo_tests.svh"

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+dv
design/udp_echo_pkg.sv
design/stream_fifo.sv
design/udp_rx_steer.sv
design/udp_tx_sequencer.sv
design/udp_echo_top.sv
dv/udp_echo_tb.sv
